//--- flist.f
+incdir+tests
source/icache_pkg.sv
source/way_store.sv
source/set_lookup.sv
source/inst_select.sv
source/miss_tracker.sv
source/fill_unit.sv
source/icache_top.sv
tests/icache_tb.sv

//--- source/fill_unit.sv
`timescale 1ns/1ps

module fill_unit (
  input  logic                clk,
  input  logic                reset,
  // memory response
  input  logic                mem_resp_valid_i,
  input  icache_pkg::tag_t    mem_resp_tag_i,
  input  icache_pkg::index_t  mem_resp_index_i,
  input  icache_pkg::line_t   mem_resp_data_i,
  // mshr state
  input  logic                mshr_busy_i,
  input  icache_pkg::tag_t    mshr_tag_i,
  input  icache_pkg::index_t  mshr_index_i,
  input  icache_pkg::way_t    mshr_way_i,
  // victim lookup
  input  icache_pkg::index_t  victim_index_i,
  output icache_pkg::way_t    victim_way_o,
  // registered fill
  output logic                fill_valid_o,
  output icache_pkg::index_t  fill_index_o,
  output icache_pkg::tag_t    fill_tag_o,
  output icache_pkg::way_t    fill_way_o,
  output icache_pkg::line_t   fill_line_o
);

  import icache_pkg::*;

  // response belongs to the outstanding miss
  logic resp_match;
  // a fill to the victim set is retiring right now
  logic fill_same_set;

  // round-robin pointer per set
  way_t rr_ptr_q [NUM_SETS];

  ////////////////////
  // response match
  ////////////////////

  assign resp_match = mem_resp_valid_i & mshr_busy_i &
                      (mem_resp_tag_i == mshr_tag_i) &
                      (mem_resp_index_i == mshr_index_i);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      fill_valid_o <= 1'b0;
    else
      fill_valid_o <= resp_match;
  end

  always_ff @(posedge clk)
  begin
    if (resp_match)
    begin
      fill_index_o <= mshr_index_i;
      fill_tag_o   <= mshr_tag_i;
      fill_way_o   <= mshr_way_i;
      fill_line_o  <= mem_resp_data_i;
    end
  end

  ////////////////////
  // replacement
  ////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int s = 0; s < NUM_SETS; s++)
      begin
        rr_ptr_q[s] <= '0;
      end
    end
    else if (fill_valid_o)
    begin
      // wraps modulo NUM_WAYS by width
      rr_ptr_q[fill_index_o] <= rr_ptr_q[fill_index_o] + 1'b1;
    end
  end

  // look past a fill to the same set so a new miss never picks the way being written
  assign fill_same_set = fill_valid_o & (fill_index_o == victim_index_i);
  assign victim_way_o  = rr_ptr_q[victim_index_i] + way_t'(fill_same_set);

endmodule

//--- source/icache_pkg.sv
package icache_pkg;

  ////////////////////
  // cache geometry
  ////////////////////

  localparam int PC_BITS       = 32;
  localparam int INST_BITS     = 32;
  // byte bits below each instruction
  localparam int INST_BYTE_LOG = 2;
  localparam int INSTS_IN_LINE = 4;
  localparam int OFFSET_BITS   = 2;
  localparam int NUM_SETS      = 16;
  localparam int INDEX_BITS    = 4;
  localparam int NUM_WAYS      = 4;
  localparam int WAY_BITS      = 2;
  localparam int TAG_BITS      = PC_BITS - INDEX_BITS - OFFSET_BITS - INST_BYTE_LOG;
  localparam int LINE_BITS     = INSTS_IN_LINE * INST_BITS;
  localparam int FETCH_WIDTH   = 2;

  // lsb positions of the pc fields
  // pc = tag | index | offset | byte
  localparam int OFFSET_LSB = INST_BYTE_LOG;
  localparam int INDEX_LSB  = OFFSET_LSB + OFFSET_BITS;
  localparam int TAG_LSB    = INDEX_LSB + INDEX_BITS;

  ////////////////////
  // shared types
  ////////////////////

  typedef logic [PC_BITS-1:0]              pc_t;
  typedef logic [INST_BITS-1:0]            inst_t;
  typedef logic [TAG_BITS-1:0]             tag_t;
  typedef logic [INDEX_BITS-1:0]           index_t;
  typedef logic [OFFSET_BITS-1:0]          offset_t;
  typedef logic [WAY_BITS-1:0]             way_t;
  typedef logic [LINE_BITS-1:0]            line_t;
  // block address sent to memory, tag over index
  typedef logic [TAG_BITS+INDEX_BITS-1:0]  block_addr_t;
  typedef logic [NUM_WAYS-1:0]             hit_vec_t;
  typedef logic [FETCH_WIDTH-1:0]          slot_valid_t;

endpackage

//--- source/icache_top.sv
`timescale 1ns/1ps

module icache_top (
  input  logic                     clk,
  input  logic                     reset,
  // fetch interface
  input  logic                     fetch_req_i,
  input  icache_pkg::pc_t          pc_i,
  output icache_pkg::inst_t        inst_o [icache_pkg::FETCH_WIDTH],
  output icache_pkg::slot_valid_t  inst_valid_o,
  // memory request
  output logic                     mem_req_valid_o,
  output icache_pkg::block_addr_t  mem_req_addr_o,
  output icache_pkg::way_t         mem_req_way_o,
  // memory response
  input  logic                     mem_resp_valid_i,
  input  icache_pkg::tag_t         mem_resp_tag_i,
  input  icache_pkg::index_t       mem_resp_index_i,
  input  icache_pkg::line_t        mem_resp_data_i,
  // maintenance
  input  logic                     inv_i,
  input  icache_pkg::index_t       inv_index_i,
  input  icache_pkg::way_t         inv_way_i,
  input  logic                     flush_i,
  output logic                     flush_done_o
);

  import icache_pkg::*;

  // lookup to select and miss
  hit_vec_t hit_vec;
  line_t    hit_line;
  logic     hit;

  // miss to fill
  index_t   victim_index;
  way_t     victim_way;
  logic     mshr_busy;
  tag_t     mshr_tag;
  index_t   mshr_index;
  way_t     mshr_way;

  // fill back to lookup and miss
  logic     fill_valid;
  index_t   fill_index;
  tag_t     fill_tag;
  way_t     fill_way;
  line_t    fill_line;

  ////////////////////
  // stages
  ////////////////////

  set_lookup u_lookup (
    .clk(clk), .reset(reset),
    .fetch_req_i(fetch_req_i), .pc_i(pc_i),
    .fill_valid_i(fill_valid), .fill_index_i(fill_index), .fill_tag_i(fill_tag),
    .fill_way_i(fill_way), .fill_line_i(fill_line),
    .inv_i(inv_i), .inv_index_i(inv_index_i), .inv_way_i(inv_way_i),
    .flush_i(flush_i),
    .hit_vec_o(hit_vec), .hit_line_o(hit_line), .hit_o(hit)
  );

  inst_select u_select (
    .pc_i(pc_i), .hit_vec_i(hit_vec), .hit_line_i(hit_line),
    .inst_o(inst_o), .inst_valid_o(inst_valid_o)
  );

  miss_tracker u_miss (
    .clk(clk), .reset(reset),
    .fetch_req_i(fetch_req_i), .pc_i(pc_i), .hit_i(hit),
    .victim_way_i(victim_way), .fill_valid_i(fill_valid),
    .victim_index_o(victim_index),
    .mshr_busy_o(mshr_busy), .mshr_tag_o(mshr_tag),
    .mshr_index_o(mshr_index), .mshr_way_o(mshr_way),
    .mem_req_valid_o(mem_req_valid_o), .mem_req_addr_o(mem_req_addr_o),
    .mem_req_way_o(mem_req_way_o)
  );

  fill_unit u_fill (
    .clk(clk), .reset(reset),
    .mem_resp_valid_i(mem_resp_valid_i), .mem_resp_tag_i(mem_resp_tag_i),
    .mem_resp_index_i(mem_resp_index_i), .mem_resp_data_i(mem_resp_data_i),
    .mshr_busy_i(mshr_busy), .mshr_tag_i(mshr_tag),
    .mshr_index_i(mshr_index), .mshr_way_i(mshr_way),
    .victim_index_i(victim_index), .victim_way_o(victim_way),
    .fill_valid_o(fill_valid), .fill_index_o(fill_index), .fill_tag_o(fill_tag),
    .fill_way_o(fill_way), .fill_line_o(fill_line)
  );

  ////////////////////
  // flush done
  ////////////////////

  // valid bits clear on the edge after flush_i, done follows one cycle later
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      flush_done_o <= 1'b0;
    else
      flush_done_o <= flush_i;
  end

endmodule

//--- source/inst_select.sv
`timescale 1ns/1ps

module inst_select (
  input  icache_pkg::pc_t          pc_i,
  input  icache_pkg::hit_vec_t     hit_vec_i,
  input  icache_pkg::line_t        hit_line_i,
  // fetch group, slot 0 is the instruction at pc
  output icache_pkg::inst_t        inst_o [icache_pkg::FETCH_WIDTH],
  output icache_pkg::slot_valid_t  inst_valid_o
);

  import icache_pkg::*;

  // word offset of the fetch pc inside the line
  offset_t pc_offset;
  // any way hit
  logic    fetch_hit;
  // slot still lies inside the line
  logic [FETCH_WIDTH-1:0] in_line;

  assign pc_offset = pc_i[OFFSET_LSB +: OFFSET_BITS];
  assign fetch_hit = |hit_vec_i;

  ////////////////////
  // per slot extract
  ////////////////////

  for (genvar s = 0; s < FETCH_WIDTH; s++)
  begin : g_slot
    // one extra bit so we can see the group run off the line
    logic [OFFSET_BITS:0] word_pos;
    offset_t              word_idx;

    assign word_pos = {1'b0, pc_offset} + (OFFSET_BITS+1)'(s);
    assign word_idx = word_pos[OFFSET_BITS-1:0];

    assign in_line[s] = word_pos < (OFFSET_BITS+1)'(INSTS_IN_LINE);

    // past the end of the line the slot carries zero
    assign inst_o[s] = in_line[s] ? hit_line_i[word_idx*INST_BITS +: INST_BITS] : '0;

    // slot 0 is always inside the line, so it is valid on any hit
    assign inst_valid_o[s] = fetch_hit & in_line[s];
  end

endmodule

//--- source/miss_tracker.sv
`timescale 1ns/1ps

module miss_tracker (
  input  logic                     clk,
  input  logic                     reset,
  // fetch side
  input  logic                     fetch_req_i,
  input  icache_pkg::pc_t          pc_i,
  input  logic                     hit_i,
  // victim lookup in the fill stage
  input  icache_pkg::way_t         victim_way_i,
  input  logic                     fill_valid_i,
  output icache_pkg::index_t       victim_index_o,
  // mshr state for response matching
  output logic                     mshr_busy_o,
  output icache_pkg::tag_t         mshr_tag_o,
  output icache_pkg::index_t       mshr_index_o,
  output icache_pkg::way_t         mshr_way_o,
  // memory request
  output logic                     mem_req_valid_o,
  output icache_pkg::block_addr_t  mem_req_addr_o,
  output icache_pkg::way_t         mem_req_way_o
);

  import icache_pkg::*;

  // pc fields of the previous cycle
  tag_t   pc_tag_q;
  index_t pc_index_q;

  // delayed miss flags
  logic miss_d1;
  logic miss_d2;
  logic miss_pulse;
  // request that actually goes out
  logic req_accept;

  ////////////////////
  // pc capture
  ////////////////////

  // the request goes out a cycle after the miss, so the fields are held one cycle
  always_ff @(posedge clk)
  begin
    pc_tag_q   <= pc_i[TAG_LSB +: TAG_BITS];
    pc_index_q <= pc_i[INDEX_LSB +: INDEX_BITS];
  end

  ////////////////////
  // miss pulse
  ////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      miss_d1 <= 1'b0;
      miss_d2 <= 1'b0;
    end
    else
    begin
      // a fill clears both flags so a fetch still missing
      // afterwards gets a fresh pulse
      miss_d1 <= fetch_req_i & ~hit_i & ~fill_valid_i;
      miss_d2 <= miss_d1 & ~fill_valid_i;
    end
  end

  // rising edge of the delayed miss, one pulse per standing miss
  assign miss_pulse = miss_d1 & ~miss_d2;

  // mshr must be free, or freed by a fill in this same cycle
  // a dropped request is replayed by fetch
  assign req_accept = miss_pulse & (~mshr_busy_o | fill_valid_i);

  ////////////////////
  // mshr
  ////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      mshr_busy_o <= 1'b0;
    end
    else if (req_accept)
    begin
      // also covers fill and request together, the mshr reloads
      mshr_busy_o <= 1'b1;
    end
    else if (fill_valid_i)
    begin
      mshr_busy_o <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (req_accept)
    begin
      mshr_tag_o   <= pc_tag_q;
      mshr_index_o <= pc_index_q;
      // the fill goes to the way reported with the request
      mshr_way_o   <= victim_way_i;
    end
  end

  // victim pointer is read for the set of the registered miss
  assign victim_index_o = pc_index_q;

  // request outputs
  assign mem_req_valid_o = req_accept;
  assign mem_req_addr_o  = {pc_tag_q, pc_index_q};
  assign mem_req_way_o   = victim_way_i;

endmodule

//--- source/set_lookup.sv
`timescale 1ns/1ps

module set_lookup (
  input  logic                  clk,
  input  logic                  reset,
  // fetch side
  input  logic                  fetch_req_i,
  input  icache_pkg::pc_t       pc_i,
  // line fill from the fill stage
  input  logic                  fill_valid_i,
  input  icache_pkg::index_t    fill_index_i,
  input  icache_pkg::tag_t      fill_tag_i,
  input  icache_pkg::way_t      fill_way_i,
  input  icache_pkg::line_t     fill_line_i,
  // single line invalidation
  input  logic                  inv_i,
  input  icache_pkg::index_t    inv_index_i,
  input  icache_pkg::way_t      inv_way_i,
  // whole cache flush
  input  logic                  flush_i,
  // lookup results
  output icache_pkg::hit_vec_t  hit_vec_o,
  output icache_pkg::line_t     hit_line_o,
  output logic                  hit_o
);

  import icache_pkg::*;

  // pc fields used by the lookup
  tag_t   pc_tag;
  index_t pc_index;

  // per way read data for the fetch index
  tag_t  tag_rd  [NUM_WAYS];
  line_t data_rd [NUM_WAYS];

  // valid bits, one vector of sets per way
  logic [NUM_SETS-1:0] valid_q [NUM_WAYS];

  assign pc_tag   = pc_i[TAG_LSB +: TAG_BITS];
  assign pc_index = pc_i[INDEX_LSB +: INDEX_BITS];

  ////////////////////
  // tag and data ways
  ////////////////////

  for (genvar w = 0; w < NUM_WAYS; w++)
  begin : g_way
    logic wr_en;

    // only the victim way recorded for the fill is written
    assign wr_en = fill_valid_i & (fill_way_i == way_t'(w));

    way_store #(.entry_t(tag_t)) u_tag (
      .clk        (clk),
      .reset      (reset),
      .rd_index_i (pc_index),
      .wr_en_i    (wr_en),
      .wr_index_i (fill_index_i),
      .wr_data_i  (fill_tag_i),
      .rd_data_o  (tag_rd[w])
    );

    way_store #(.entry_t(line_t)) u_data (
      .clk        (clk),
      .reset      (reset),
      .rd_index_i (pc_index),
      .wr_en_i    (wr_en),
      .wr_index_i (fill_index_i),
      .wr_data_i  (fill_line_i),
      .rd_data_o  (data_rd[w])
    );

    // hit needs a live fetch, a valid line and a tag match
    assign hit_vec_o[w] = fetch_req_i & valid_q[w][pc_index] & (tag_rd[w] == pc_tag);
  end

  ////////////////////
  // valid bits
  ////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int w = 0; w < NUM_WAYS; w++)
      begin
        valid_q[w] <= '0;
      end
    end
    else if (flush_i)
    begin
      // flush beats everything else
      for (int w = 0; w < NUM_WAYS; w++)
      begin
        valid_q[w] <= '0;
      end
    end
    else
    begin
      if (fill_valid_i)
      begin
        valid_q[fill_way_i][fill_index_i] <= 1'b1;
      end
      // later assignment wins, so invalidation beats a fill of the same entry
      if (inv_i)
      begin
        valid_q[inv_way_i][inv_index_i] <= 1'b0;
      end
    end
  end

  ////////////////////
  // hit line mux
  ////////////////////

  always_comb
  begin
    // zero line when nothing hits
    hit_line_o = '0;
    for (int w = 0; w < NUM_WAYS; w++)
    begin
      if (hit_vec_o[w])
      begin
        hit_line_o = data_rd[w];
      end
    end
  end

  assign hit_o = |hit_vec_o;

endmodule

//--- source/way_store.sv
`timescale 1ns/1ps

module way_store #(
  parameter type entry_t = icache_pkg::tag_t
) (
  input  logic                clk,
  input  logic                reset,
  // read side, same cycle
  input  icache_pkg::index_t  rd_index_i,
  // write side, on the clock edge
  input  logic                wr_en_i,
  input  icache_pkg::index_t  wr_index_i,
  input  entry_t              wr_data_i,
  output entry_t              rd_data_o
);

  import icache_pkg::*;

  // one entry per set for this way
  entry_t mem_q [NUM_SETS];

  ////////////////////
  // write port
  ////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      // whole array cleared
      for (int s = 0; s < NUM_SETS; s++)
      begin
        mem_q[s] <= '0;
      end
    end
    else if (wr_en_i)
    begin
      mem_q[wr_index_i] <= wr_data_i;
    end
  end

  ////////////////////
  // read port
  ////////////////////

  // combinational read, a write shows up the cycle after
  assign rd_data_o = mem_q[rd_index_i];

endmodule

//--- tests/icache_tests.svh
////////////////////
// directed tests
////////////////////

// a held miss after reset gives exactly one request pulse
task automatic cold_miss();
  int req_start;
  req_start = req_count;
  // answered by hand in the next test
  auto_resp = 1'b0;
  next_tag(cold_tag);
  drive_fetch(make_pc(cold_tag, COLD_SET, '0));
  check_valid(inst_valid_o, '0, "slot valid bits on the cold miss");
  for (int n = 0; n < 10; n++)
  begin
    @(negedge clk);
    check_valid(inst_valid_o, '0, "slot valid bits while the miss is held");
  end
  stop_fetch();
  if (req_count != req_start + 1)
  begin
    mismatch_count++;
    $display("Mismatch at %0t: %0d request pulses for one held miss, expected 1",
             $time, req_count - req_start);
  end
  check_addr(last_req_addr, {cold_tag, COLD_SET}, "cold miss block address");
  check_way(last_req_way, '0, "cold miss victim way");
endtask

// the response fills the line and every offset then hits
task automatic fill_and_hit();
  int resp_start;
  resp_start = resp_count;
  // due on the next edge
  resp_due.push_back(cycle + 1);
  resp_addr.push_back({cold_tag, COLD_SET});
  wait_fill(resp_start);
  auto_resp = 1'b1;
  verify_line_hits(cold_tag, COLD_SET);
endtask

// round-robin victims in one set
task automatic replacement_order();
  way_t way;
  for (int i = 0; i < 5; i++)
  begin
    next_tag(rr_tags[i]);
  end
  for (int i = 0; i < NUM_WAYS; i++)
  begin
    miss_and_fill(rr_tags[i], RR_SET, way);
    check_way(way, way_t'(i), $sformatf("victim way of fill %0d", i));
  end
  for (int i = 0; i < NUM_WAYS; i++)
  begin
    verify_line_hits(rr_tags[i], RR_SET);
  end
  // pointer wrapped back to way 0
  miss_and_fill(rr_tags[4], RR_SET, way);
  check_way(way, '0, "victim way after the pointer wraps");
  // first tag was evicted, its refill goes to way 1
  miss_and_fill(rr_tags[0], RR_SET, way);
  check_way(way, 2'd1, "victim way of the evicted tag");
endtask

// a response for another tag must not fill anything
task automatic foreign_response();
  tag_t f_tag;
  int   req_start;
  int   resp_start;
  next_tag(f_tag);
  auto_resp = 1'b0;
  req_start = req_count;
  drive_fetch(make_pc(f_tag, FOREIGN_SET, '0));
  check_valid(inst_valid_o, '0, "slot valid bits on the miss");
  wait_request(req_start);
  stop_fetch();
  resp_start = resp_count;
  resp_due.push_back(cycle + 1);
  resp_addr.push_back({~f_tag, FOREIGN_SET});
  wait_fill(resp_start);
  drive_fetch(make_pc(f_tag, FOREIGN_SET, '0));
  check_valid(inst_valid_o, '0, "slot valid bits after a foreign response");
  stop_fetch();
  // now the real answer
  resp_start = resp_count;
  resp_due.push_back(cycle + 1);
  resp_addr.push_back({f_tag, FOREIGN_SET});
  wait_fill(resp_start);
  auto_resp = 1'b1;
  verify_line_hits(f_tag, FOREIGN_SET);
endtask

// one (set, way) cleared, the other ways of the set keep hitting
task automatic invalidate_one_line();
  way_t way;
  tag_t other_tag;
  for (int i = 0; i < NUM_WAYS; i++)
  begin
    next_tag(inv_tags[i]);
    miss_and_fill(inv_tags[i], INV_SET, way);
    check_way(way, way_t'(i), $sformatf("victim way of fill %0d", i));
  end
  // last fill lands in another set, so the fill index no longer names the invalidated set
  next_tag(other_tag);
  miss_and_fill(other_tag, FOREIGN_SET, way);
  @(posedge clk);
  inv_i       <= 1'b1;
  inv_index_i <= INV_SET;
  inv_way_i   <= 2'd2;
  @(posedge clk);
  inv_i <= 1'b0;
  for (int i = 0; i < NUM_WAYS; i++)
  begin
    if (i != 2)
    begin
      verify_line_hits(inv_tags[i], INV_SET);
    end
  end
  // way 2 held the third tag
  miss_and_fill(inv_tags[2], INV_SET, way);
endtask

// lines resident before the flush all miss after it
task automatic flush_all();
  tag_t   line_tags [$];
  index_t line_sets [$];
  way_t   way;
  line_tags.push_back(cold_tag);
  line_sets.push_back(COLD_SET);
  line_tags.push_back(rr_tags[2]);
  line_sets.push_back(RR_SET);
  line_tags.push_back(rr_tags[3]);
  line_sets.push_back(RR_SET);
  line_tags.push_back(inv_tags[1]);
  line_sets.push_back(INV_SET);
  line_tags.push_back(inv_tags[3]);
  line_sets.push_back(INV_SET);
  foreach (line_tags[i])
  begin
    verify_line_hits(line_tags[i], line_sets[i]);
  end
  @(posedge clk);
  flush_i <= 1'b1;
  @(negedge clk);
  check_flag(flush_done_o, 1'b0, "flush done in the flush cycle");
  @(posedge clk);
  flush_i <= 1'b0;
  @(negedge clk);
  check_flag(flush_done_o, 1'b1, "flush done one cycle after flush");
  @(negedge clk);
  check_flag(flush_done_o, 1'b0, "flush done after its single cycle");
  foreach (line_tags[i])
  begin
    miss_and_fill(line_tags[i], line_sets[i], way);
  end
endtask

//--- tests/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

  import icache_pkg::*;

  // watchdog, about four times the run length
  localparam int MAX_CYCLES = 2000;
  // cycles from a request to its answer
  localparam int RESP_DELAY = 4;
  // longest wait for a request or a response
  localparam int WAIT_LIMIT = 50;

  // sets used by the tests, one per test so they do not disturb each other
  localparam index_t COLD_SET    = 4'd1;
  localparam index_t RR_SET      = 4'd5;
  localparam index_t FOREIGN_SET = 4'd9;
  localparam index_t INV_SET     = 4'd12;

  logic        clk;
  logic        reset;
  logic        fetch_req_i;
  pc_t         pc_i;
  inst_t       inst_o [FETCH_WIDTH];
  slot_valid_t inst_valid_o;
  logic        mem_req_valid_o;
  block_addr_t mem_req_addr_o;
  way_t        mem_req_way_o;
  logic        mem_resp_valid_i;
  tag_t        mem_resp_tag_i;
  index_t      mem_resp_index_i;
  line_t       mem_resp_data_i;
  logic        inv_i;
  index_t      inv_index_i;
  way_t        inv_way_i;
  logic        flush_i;
  logic        flush_done_o;

  // error counts
  int mismatch_count;
  int other_errors;
  int cycle;

  // request log and response queue of the memory model
  int          req_count;
  int          resp_count;
  block_addr_t last_req_addr;
  way_t        last_req_way;
  logic        auto_resp;
  int          resp_due [$];
  block_addr_t resp_addr [$];
  block_addr_t resp_now;

  // tags handed out so far, all distinct
  logic [31:0] rng_state;
  tag_t        used_tags [$];
  tag_t        cold_tag;
  tag_t        rr_tags [5];
  tag_t        inv_tags [NUM_WAYS];

  icache_top dut0 (
    .clk(clk), .reset(reset),
    .fetch_req_i(fetch_req_i), .pc_i(pc_i),
    .inst_o(inst_o), .inst_valid_o(inst_valid_o),
    .mem_req_valid_o(mem_req_valid_o), .mem_req_addr_o(mem_req_addr_o),
    .mem_req_way_o(mem_req_way_o),
    .mem_resp_valid_i(mem_resp_valid_i), .mem_resp_tag_i(mem_resp_tag_i),
    .mem_resp_index_i(mem_resp_index_i), .mem_resp_data_i(mem_resp_data_i),
    .inv_i(inv_i), .inv_index_i(inv_index_i), .inv_way_i(inv_way_i),
    .flush_i(flush_i), .flush_done_o(flush_done_o)
  );

  always #5 clk = ~clk;

  ////////////////////
  // memory model
  ////////////////////

  // word w of a block is the block address times 4 plus w
  function automatic inst_t mem_word(input block_addr_t addr, input int w);
    return inst_t'(addr) * 4 + inst_t'(w);
  endfunction

  function automatic line_t mem_line(input block_addr_t addr);
    line_t line;
    line = '0;
    for (int w = 0; w < INSTS_IN_LINE; w++)
    begin
      line[w*INST_BITS +: INST_BITS] = mem_word(addr, w);
    end
    return line;
  endfunction

  // logs every request pulse and answers from the queue when due
  always @(posedge clk)
  begin
    if (!reset && mem_req_valid_o)
    begin
      req_count++;
      last_req_addr = mem_req_addr_o;
      last_req_way  = mem_req_way_o;
      if (auto_resp)
      begin
        resp_due.push_back(cycle + RESP_DELAY);
        resp_addr.push_back(mem_req_addr_o);
      end
    end
    if (resp_due.size() > 0 && cycle >= resp_due[0])
    begin
      resp_now = resp_addr.pop_front();
      void'(resp_due.pop_front());
      mem_resp_valid_i <= 1'b1;
      mem_resp_tag_i   <= resp_now[INDEX_BITS +: TAG_BITS];
      mem_resp_index_i <= resp_now[INDEX_BITS-1:0];
      mem_resp_data_i  <= mem_line(resp_now);
      resp_count++;
    end
    else
    begin
      mem_resp_valid_i <= 1'b0;
    end
  end

  // watchdog
  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Some tests failed");
      $finish;
    end
  end

  ////////////////////
  // compare tasks
  ////////////////////

  task automatic check_inst(input inst_t got, input inst_t exp, input string what);
    if (got !== exp)
    begin
      mismatch_count++;
      $display("Mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_valid(input slot_valid_t got, input slot_valid_t exp, input string what);
    if (got !== exp)
    begin
      mismatch_count++;
      $display("Mismatch at %0t: %s, got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input block_addr_t got, input block_addr_t exp, input string what);
    if (got !== exp)
    begin
      mismatch_count++;
      $display("Mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_way(input way_t got, input way_t exp, input string what);
    if (got !== exp)
    begin
      mismatch_count++;
      $display("Mismatch at %0t: %s, got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      mismatch_count++;
      $display("Mismatch at %0t: %s, got %b expected %b", $time, what, got, exp);
    end
  endtask

  ////////////////////
  // stimulus helpers
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // draws tags until one comes up that was never used
  task automatic next_tag(output tag_t t);
    logic fresh;
    fresh = 1'b0;
    while (!fresh)
    begin
      rng_state = xorshift32(rng_state);
      t         = rng_state[TAG_BITS-1:0];
      fresh     = 1'b1;
      foreach (used_tags[i])
      begin
        if (used_tags[i] == t)
        begin
          fresh = 1'b0;
        end
      end
    end
    used_tags.push_back(t);
  endtask

  function automatic pc_t make_pc(input tag_t tag, input index_t index, input offset_t offset);
    return {tag, index, offset, {INST_BYTE_LOG{1'b0}}};
  endfunction

  // fetch driven on the edge, outputs looked at mid cycle
  task automatic drive_fetch(input pc_t pc);
    @(posedge clk);
    fetch_req_i <= 1'b1;
    pc_i        <= pc;
    @(negedge clk);
  endtask

  task automatic stop_fetch();
    @(posedge clk);
    fetch_req_i <= 1'b0;
  endtask

  task automatic wait_request(input int start);
    int n;
    n = 0;
    while (req_count == start && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (req_count == start)
    begin
      other_errors++;
      $display("No memory request was seen by %0t", $time);
    end
  endtask

  // the line hits from the second cycle after the response
  task automatic wait_fill(input int start);
    int n;
    n = 0;
    while (resp_count == start && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (resp_count == start)
    begin
      other_errors++;
      $display("No memory response was sent by %0t", $time);
    end
    repeat (2) @(posedge clk);
  endtask

  // fetch that must miss, its request checked and its fill waited for
  task automatic miss_and_fill(input tag_t tag, input index_t index, output way_t way);
    int req_start;
    int resp_start;
    req_start  = req_count;
    resp_start = resp_count;
    drive_fetch(make_pc(tag, index, '0));
    check_valid(inst_valid_o, '0, "slot valid bits on a miss");
    wait_request(req_start);
    check_addr(last_req_addr, {tag, index}, "request block address");
    way = last_req_way;
    stop_fetch();
    wait_fill(resp_start);
  endtask

  // all four offsets of a resident line
  task automatic verify_line_hits(input tag_t tag, input index_t index);
    block_addr_t addr;
    slot_valid_t exp_valid;
    inst_t       exp_next;
    addr = {tag, index};
    for (int o = 0; o < INSTS_IN_LINE; o++)
    begin
      drive_fetch(make_pc(tag, index, offset_t'(o)));
      // slot 1 runs off the line at the last word
      exp_valid = {o + 1 < INSTS_IN_LINE, 1'b1};
      exp_next  = (o + 1 < INSTS_IN_LINE) ? mem_word(addr, o + 1) : '0;
      check_valid(inst_valid_o, exp_valid, $sformatf("slot valid bits at offset %0d", o));
      check_inst(inst_o[0], mem_word(addr, o), $sformatf("slot 0 at offset %0d", o));
      check_inst(inst_o[1], exp_next, $sformatf("slot 1 at offset %0d", o));
    end
    stop_fetch();
  endtask

  `include "icache_tests.svh"

  ////////////////////
  // main sequence
  ////////////////////

  initial
  begin
    clk              = 1'b0;
    reset            = 1'b1;
    fetch_req_i      = 1'b0;
    pc_i             = '0;
    mem_resp_valid_i = 1'b0;
    mem_resp_tag_i   = '0;
    mem_resp_index_i = '0;
    mem_resp_data_i  = '0;
    inv_i            = 1'b0;
    inv_index_i      = '0;
    inv_way_i        = '0;
    flush_i          = 1'b0;
    mismatch_count   = 0;
    other_errors     = 0;
    cycle            = 0;
    req_count        = 0;
    resp_count       = 0;
    auto_resp        = 1'b1;
    rng_state        = 32'd4273;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    cold_miss();
    fill_and_hit();
    replacement_order();
    foreign_response();
    invalidate_one_line();
    flush_all();
    repeat (3) @(posedge clk);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_errors);
    if (mismatch_count == 0 && other_errors == 0)
    begin
      $display("All tests passed");
    end
    else
    begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
